//--- verilog/skew_geom_pkg.sv
/*
  Geometry of the systolic operand front end.
  LANES is also the skew depth and the read threshold, so changing it
  moves the diagonal length and the fill latency together.
  VEC_W is always LANES * DATA_W, lane 0 in the low bits.
*/
`default_nettype none

package skew_geom_pkg;

    // ==============================
    // Array shape
    // ==============================

    // Lanes per vector, one bank each
    localparam int unsigned LANES = 4;

    // Element width
    localparam int unsigned DATA_W = 8;

    // Flat vector bus width
    // lane j sits at [j*DATA_W +: DATA_W]
    localparam int unsigned VEC_W = LANES * DATA_W;

endpackage

`default_nettype wire

//--- verilog/skew_mem_pkg.sv
/*
  Bank storage sizes for the skew buffer.
  DEPTH must be a power of two and at least LANES, otherwise the
  shifted write addresses alias before the diagonal is complete.
*/
`default_nettype none

package skew_mem_pkg;

    // ==============================
    // Bank addressing
    // ==============================

    localparam int unsigned ADDR_W = 3;

    // Words per bank, pointers wrap at this size
    localparam int unsigned DEPTH = 1 << ADDR_W;

    // Occupancy 0..DEPTH needs one extra bit
    localparam int unsigned CNT_W = ADDR_W + 1;

    // Reads wait until a whole diagonal is stored
    localparam logic [CNT_W-1:0] READ_MIN = CNT_W'(skew_geom_pkg::LANES);

endpackage

`default_nettype wire

//--- verilog/dp_bank.sv
/*
  Single lane bank, one write port and one registered read port.
  Read during write to the same address returns the old word.
  The read data register holds until rready, and a new read may be
  issued in the cycle that the pending one is accepted.
*/
`timescale 1ns/1ns
`default_nettype none

module dp_bank (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    // Write port
    input  wire logic                              wvalid,
    input  wire logic [skew_mem_pkg::ADDR_W-1:0]   waddr,
    input  wire logic [skew_geom_pkg::DATA_W-1:0]  wdata,
    // Read address port
    input  wire logic                              arvalid,
    input  wire logic [skew_mem_pkg::ADDR_W-1:0]   araddr,
    // Read data port
    output logic                                   rvalid,
    input  wire logic                              rready,
    output logic      [skew_geom_pkg::DATA_W-1:0]  rdata
);

    // ==============================
    // Storage
    // ==============================

    // Lane memory, no reset on contents
    logic [skew_geom_pkg::DATA_W-1:0] mem [skew_mem_pkg::DEPTH];

    // Write takes effect at the edge
    always_ff @(posedge clk) begin
        if (wvalid) begin
            mem[waddr] <= wdata;
        end
    end

    // ==============================
    // Read port
    // ==============================

    // Data register loads on every issued read
    // Caller only issues when the slot is free or draining
    always_ff @(posedge clk) begin
        if (arvalid) begin
            rdata <= mem[araddr];
        end
    end

    // Valid flag for the data register
    // New issue wins over a simultaneous accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/row_loader.sv
/*
  Four-phase req/ack receiver feeding the skew buffer.
  Source must hold in_data and in_mask stable while in_req is high
  and ack is low. in_ack is withheld until the buffer takes the vector.
*/
`timescale 1ns/1ns
`default_nettype none

module row_loader (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    // Outside, four-phase
    input  wire logic                              in_req,
    input  wire logic [skew_geom_pkg::VEC_W-1:0]   in_data,
    input  wire logic [skew_geom_pkg::LANES-1:0]   in_mask,
    output logic                                   in_ack,
    // Toward buffer, valid/ready
    output logic                                   wr_vld,
    output logic      [skew_geom_pkg::VEC_W-1:0]   wr_data,
    output logic      [skew_geom_pkg::LANES-1:0]   wr_mask,
    input  wire logic                              wr_rdy
);

    // ==============================
    // Handshake FSM
    // ==============================

    // State lives in the two outputs
    //   idle  : wr_vld=0 in_ack=0
    //   offer : wr_vld=1 in_ack=0
    //   ack   : wr_vld=0 in_ack=1
    logic idle;

    assign idle = !wr_vld && !in_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_vld <= 1'b0;
            in_ack <= 1'b0;
        end else if (idle && in_req) begin
            // New request, start offering
            wr_vld <= 1'b1;
        end else if (wr_vld && wr_rdy) begin
            // Buffer took it, acknowledge source
            wr_vld <= 1'b0;
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            // Source released req, return to idle
            in_ack <= 1'b0;
        end
    end

    // Payload copy taken with the request
    // source bus is free once ack is up
    always_ff @(posedge clk) begin
        if (idle && in_req) begin
            wr_data <= in_data;
            wr_mask <= in_mask;
        end
    end

endmodule

`default_nettype wire

//--- verilog/skew_buffer.sv
/*
  Diagonal skew buffer in front of the systolic array.
  shift=1 writes lane j at wptr-j, shift=0 writes every lane at wptr.
  No guard against shifted writes landing on unread addresses.
  A read needs READ_MIN stored vectors, so the last READ_MIN-1
  vectors stay inside until more arrive. Change shift only after clear.
*/
`timescale 1ns/1ns
`default_nettype none

module skew_buffer (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              clear,
    input  wire logic                              shift,
    // Write side, valid/ready
    input  wire logic                              wr_vld,
    input  wire logic [skew_geom_pkg::VEC_W-1:0]   wr_data,
    input  wire logic [skew_geom_pkg::LANES-1:0]   wr_mask,
    output logic                                   wr_rdy,
    // Read side, valid/ready
    output logic                                   rd_vld,
    output logic      [skew_geom_pkg::VEC_W-1:0]   rd_data,
    input  wire logic                              rd_rdy
);

    // ==============================
    // Control state
    // ==============================

    logic [skew_mem_pkg::ADDR_W-1:0] wr_ptr;
    logic [skew_mem_pkg::ADDR_W-1:0] rd_ptr;
    logic [skew_mem_pkg::CNT_W-1:0]  count;

    logic                            full;
    logic                            can_read;
    logic                            push;
    logic                            issue;

    // Per lane signals
    logic [skew_geom_pkg::LANES-1:0] lane_wen;
    logic [skew_geom_pkg::LANES-1:0] lane_rvalid;
    logic [skew_mem_pkg::ADDR_W-1:0] lane_waddr [skew_geom_pkg::LANES];

    // Count tops out at DEPTH, a power of two, so the MSB means full
    assign full     = count[skew_mem_pkg::ADDR_W];
    assign can_read = count >= skew_mem_pkg::READ_MIN;

    assign wr_rdy   = !full;
    assign push     = wr_vld && !full;

    // All lanes issue together, so their valids agree
    assign rd_vld   = &lane_rvalid;

    // Issue when the output slot is empty or being taken this cycle
    assign issue    = can_read && (!rd_vld || rd_rdy);

    // Masked lanes keep their old word
    assign lane_wen = wr_mask & {skew_geom_pkg::LANES{push}};

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (clear) begin
            rd_ptr <= '0;
        end else if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Simultaneous push and issue leave the count unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (push && !issue) begin
            count <= count + 1'b1;
        end else if (issue && !push) begin
            count <= count - 1'b1;
        end
    end

    // ==============================
    // Bank array
    // ==============================

    for (genvar j = 0; j < skew_geom_pkg::LANES; j++) begin : g_lane
        // Diagonal offset, wraps modulo DEPTH
        assign lane_waddr[j] = shift ? wr_ptr - skew_mem_pkg::ADDR_W'(j) : wr_ptr;

        dp_bank u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .wvalid  (lane_wen[j]),
            .waddr   (lane_waddr[j]),
            .wdata   (wr_data[j*skew_geom_pkg::DATA_W +: skew_geom_pkg::DATA_W]),
            .arvalid (issue),
            .araddr  (rd_ptr),
            .rvalid  (lane_rvalid[j]),
            .rready  (rd_rdy),
            .rdata   (rd_data[j*skew_geom_pkg::DATA_W +: skew_geom_pkg::DATA_W])
        );
    end

endmodule

`default_nettype wire

//--- verilog/column_drain.sv
/*
  Output stage, accepts one vector from the buffer and presents it
  over a four-phase req/ack handshake. Holds one vector at a time, so
  throughput is bounded by the sink's full four-phase cycle.
*/
`timescale 1ns/1ns
`default_nettype none

module column_drain (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    // From buffer, valid/ready
    input  wire logic                              rd_vld,
    input  wire logic [skew_geom_pkg::VEC_W-1:0]   rd_data,
    output logic                                   rd_rdy,
    // Outside, four-phase
    output logic                                   out_req,
    output logic      [skew_geom_pkg::VEC_W-1:0]   out_data,
    input  wire logic                              out_ack
);

    // ==============================
    // Handshake FSM
    // ==============================

    // Set after ack seen high, cleared when it drops
    logic wait_fall;

    // Ready only when idle
    assign rd_rdy = !out_req && !wait_fall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req   <= 1'b0;
            wait_fall <= 1'b0;
        end else if (rd_vld && rd_rdy) begin
            // Captured, raise request
            out_req <= 1'b1;
        end else if (out_req && out_ack) begin
            // Sink has it, drop request
            out_req   <= 1'b0;
            wait_fall <= 1'b1;
        end else if (wait_fall && !out_ack) begin
            // Return phase done
            wait_fall <= 1'b0;
        end
    end

    // Held across the whole four-phase cycle
    always_ff @(posedge clk) begin
        if (rd_vld && rd_rdy) begin
            out_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/skew_top.sv
/*
  Operand skew front end, loader -> skew buffer -> drain.
  Both outside ports are four-phase req/ack.
  clear and shift act on the buffer only, shift may change after clear.
*/
`timescale 1ns/1ns
`default_nettype none

module skew_top (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              clear,
    input  wire logic                              shift,
    // Input port
    input  wire logic                              in_req,
    input  wire logic [skew_geom_pkg::VEC_W-1:0]   in_data,
    input  wire logic [skew_geom_pkg::LANES-1:0]   in_mask,
    output logic                                   in_ack,
    // Output port
    output logic                                   out_req,
    output logic      [skew_geom_pkg::VEC_W-1:0]   out_data,
    input  wire logic                              out_ack
);

    // ==============================
    // Internal links
    // ==============================

    // Loader to buffer
    logic                              wr_vld;
    logic [skew_geom_pkg::VEC_W-1:0]   wr_data;
    logic [skew_geom_pkg::LANES-1:0]   wr_mask;
    logic                              wr_rdy;

    // Buffer to drain
    logic                              rd_vld;
    logic [skew_geom_pkg::VEC_W-1:0]   rd_data;
    logic                              rd_rdy;

    row_loader u_loader (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_mask (in_mask),
        .in_ack  (in_ack),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .wr_mask (wr_mask),
        .wr_rdy  (wr_rdy)
    );

    skew_buffer u_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .shift   (shift),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .wr_mask (wr_mask),
        .wr_rdy  (wr_rdy),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .rd_rdy  (rd_rdy)
    );

    column_drain u_drain (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_vld   (rd_vld),
        .rd_data  (rd_data),
        .rd_rdy   (rd_rdy),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

endmodule

`default_nettype wire

//--- bench/skew_vectors.svh
/*
  Stimulus table, one row per input vector.
  A row with clr set starts a new session and sets the mode.
  Byte j of row r is 4*r+j, so every lane value is unique.
*/
`ifndef SKEW_VECTORS_SVH
`define SKEW_VECTORS_SVH

    typedef struct packed {
        logic                            shift;
        logic                            clr;
        logic [skew_geom_pkg::VEC_W-1:0] data;
        logic [skew_geom_pkg::LANES-1:0] mask;
    } stim_row_t;

    localparam int N_ROWS = 31;

    // Sessions of 9, 9 and 13 rows, each strands READ_MIN-1 vectors
    localparam int N_OUT_EXP = 22;

    // Sink holds ack on this output long enough to fill the buffer
    localparam int STALL_AT  = 14;
    localparam int STALL_CYC = 80;

    localparam int MAX_CYCLES = 40 * N_ROWS + 200;

    localparam stim_row_t STIM [N_ROWS] = '{
        // Fifo, full masks, covers every address
        {1'b0, 1'b0, 32'h03020100, 4'hf}, {1'b0, 1'b0, 32'h07060504, 4'hf},
        {1'b0, 1'b0, 32'h0b0a0908, 4'hf}, {1'b0, 1'b0, 32'h0f0e0d0c, 4'hf},
        {1'b0, 1'b0, 32'h13121110, 4'hf}, {1'b0, 1'b0, 32'h17161514, 4'hf},
        {1'b0, 1'b0, 32'h1b1a1918, 4'hf}, {1'b0, 1'b0, 32'h1f1e1d1c, 4'hf},
        {1'b0, 1'b0, 32'h23222120, 4'hf},
        // Clear into shift mode, two partial masks
        {1'b1, 1'b1, 32'h27262524, 4'hf}, {1'b1, 1'b0, 32'h2b2a2928, 4'hf},
        {1'b1, 1'b0, 32'h2f2e2d2c, 4'hf}, {1'b1, 1'b0, 32'h33323130, 4'h5},
        {1'b1, 1'b0, 32'h37363534, 4'hf}, {1'b1, 1'b0, 32'h3b3a3938, 4'ha},
        {1'b1, 1'b0, 32'h3f3e3d3c, 4'hf}, {1'b1, 1'b0, 32'h43424140, 4'hf},
        {1'b1, 1'b0, 32'h47464544, 4'hf},
        // Clear back to fifo, sink stall fills the buffer
        {1'b0, 1'b1, 32'h4b4a4948, 4'hf}, {1'b0, 1'b0, 32'h4f4e4d4c, 4'hf},
        {1'b0, 1'b0, 32'h53525150, 4'h3}, {1'b0, 1'b0, 32'h57565554, 4'hf},
        {1'b0, 1'b0, 32'h5b5a5958, 4'hf}, {1'b0, 1'b0, 32'h5f5e5d5c, 4'hf},
        {1'b0, 1'b0, 32'h63626160, 4'hf}, {1'b0, 1'b0, 32'h67666564, 4'hc},
        {1'b0, 1'b0, 32'h6b6a6968, 4'hf}, {1'b0, 1'b0, 32'h6f6e6d6c, 4'hf},
        {1'b0, 1'b0, 32'h73727170, 4'hf}, {1'b0, 1'b0, 32'h77767574, 4'hf},
        {1'b0, 1'b0, 32'h7b7a7978, 4'hf}
    };

`endif

//--- bench/tb_skew_top.sv
/*
  Testbench for skew_top with a model of the lane banks.
  An expected vector is taken when a whole diagonal is stored.
  Clear rows wait until every readable vector has left the DUT.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_skew_top;

`include "skew_vectors.svh"

    logic                              clk;
    logic                              rst_n;
    logic                              clear;
    logic                              shift;
    logic                              in_req;
    logic [skew_geom_pkg::VEC_W-1:0]   in_data;
    logic [skew_geom_pkg::LANES-1:0]   in_mask;
    logic                              in_ack;
    logic                              out_req;
    logic [skew_geom_pkg::VEC_W-1:0]   out_data;
    logic                              out_ack;

    // ==============================
    // Bank model
    // ==============================

    logic [skew_geom_pkg::DATA_W-1:0]  bank_model [skew_geom_pkg::LANES]
                                                  [skew_mem_pkg::DEPTH];
    logic [skew_mem_pkg::ADDR_W-1:0]   model_wptr;
    logic [skew_mem_pkg::ADDR_W-1:0]   model_rptr;
    int unsigned                       model_count;
    logic [skew_geom_pkg::VEC_W-1:0]   expect_q [$];

    int                                errors = 0;
    int                                n_out = 0;
    // Accepted inputs not yet seen at the output
    int                                held = 0;
    int                                max_held = 0;
    int                                cycles = 0;
    logic                              in_ack_d = 1'b0;
    logic                              out_req_d = 1'b0;

    skew_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .shift    (shift),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_mask  (in_mask),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // Lane j of a vector at pointer p lands at p-j in shift mode
    task automatic apply_write(input logic [skew_geom_pkg::VEC_W-1:0] data,
                               input logic [skew_geom_pkg::LANES-1:0] mask,
                               input logic sh);
        logic [skew_mem_pkg::ADDR_W-1:0] addr;
        logic [skew_mem_pkg::ADDR_W-1:0] lane_off;
        logic [skew_geom_pkg::VEC_W-1:0] snap;
        for (int j = 0; j < skew_geom_pkg::LANES; j++) begin
            lane_off = j;
            addr = sh ? model_wptr - lane_off : model_wptr;
            if (mask[j]) begin
                bank_model[j][addr] = data[j*skew_geom_pkg::DATA_W +: skew_geom_pkg::DATA_W];
            end
        end
        model_wptr++;
        model_count++;
        // Whole diagonal stored, address at rptr is now final
        if (model_count >= skew_mem_pkg::READ_MIN) begin
            for (int j = 0; j < skew_geom_pkg::LANES; j++) begin
                snap[j*skew_geom_pkg::DATA_W +: skew_geom_pkg::DATA_W] = bank_model[j][model_rptr];
            end
            expect_q.push_back(snap);
            model_rptr++;
            model_count--;
        end
    endtask

    task automatic check_output();
        logic [skew_geom_pkg::VEC_W-1:0] exp_vec;
        n_out++;
        held--;
        if (expect_q.size() == 0) begin
            $display("Output vector %0d appeared with no readable vector stored", n_out);
            errors++;
        end else begin
            exp_vec = expect_q.pop_front();
            if (out_data !== exp_vec) begin
                $display("FAILED at %0t: out_data = %h, expected %h", $time, out_data, exp_vec);
                errors++;
            end
        end
    endtask

    // Pointers restart on clear, bank contents stay
    task automatic reset_model();
        model_wptr  = '0;
        model_rptr  = '0;
        model_count = 0;
        held        = 0;
    endtask

    // Four-phase source side
    task automatic send_vector(input logic [skew_geom_pkg::VEC_W-1:0] data,
                               input logic [skew_geom_pkg::LANES-1:0] mask);
        @(posedge clk);
        #5;
        in_data = data;
        in_mask = mask;
        in_req  = 1'b1;
        do @(negedge clk); while (!in_ack);
        @(posedge clk);
        #5;
        in_req = 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    task automatic wait_drained();
        do begin
            @(negedge clk);
            #1;
        end while (expect_q.size() != 0 || out_req || out_ack);
    endtask

    // ==============================
    // Monitor, sampled mid-cycle
    // ==============================

    always @(negedge clk) begin
        if (in_ack && !in_ack_d) begin
            apply_write(in_data, in_mask, shift);
            held++;
            if (held > max_held) begin
                max_held = held;
            end
            if (held > skew_mem_pkg::DEPTH + 1) begin
                $display("Source got in_ack at %0t while the buffer was full", $time);
                errors++;
            end
        end
        if (out_req && !out_req_d) begin
            check_output();
        end
        in_ack_d  = in_ack;
        out_req_d = out_req;
    end

    // Sink, random ack delay plus one long stall
    initial begin : sink
        int unsigned delay;
        out_ack = 1'b0;
        void'($urandom(92));
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                @(posedge clk);
                if (n_out == STALL_AT) begin
                    delay = STALL_CYC;
                end else begin
                    delay = $urandom % 4;
                end
                repeat (delay) @(posedge clk);
                #5;
                out_ack = 1'b1;
                do @(negedge clk); while (out_req);
                @(posedge clk);
                #5;
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (cycles >= MAX_CYCLES);
        $display("Timeout after %0d cycles, a handshake never completed", cycles);
        $display("Some tests failed");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin : main
        rst_n   = 1'b0;
        clear   = 1'b0;
        shift   = STIM[0].shift;
        in_req  = 1'b0;
        in_data = '0;
        in_mask = '0;
        reset_model();
        for (int j = 0; j < skew_geom_pkg::LANES; j++) begin
            for (int a = 0; a < skew_mem_pkg::DEPTH; a++) begin
                bank_model[j][a] = '0;
            end
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            if (STIM[r].clr) begin
                wait_drained();
                @(posedge clk);
                #5;
                clear = 1'b1;
                shift = STIM[r].shift;
                @(posedge clk);
                #5;
                clear = 1'b0;
                reset_model();
            end
            send_vector(STIM[r].data, STIM[r].mask);
        end
        wait_drained();
        if (n_out != N_OUT_EXP) begin
            $display("FAILED at %0t: n_out = %0d, expected %0d", $time, n_out, N_OUT_EXP);
            errors++;
        end
        if (max_held != skew_mem_pkg::DEPTH + 1) begin
            $display("Sink stall never filled the buffer, peak held %0d", max_held);
            errors++;
        end
        $display("Run done: %0d outputs checked, %0d errors", n_out, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
verilog/skew_geom_pkg.sv
verilog/skew_mem_pkg.sv
verilog/dp_bank.sv
verilog/row_loader.sv
verilog/skew_buffer.sv
verilog/column_drain.sv
verilog/skew_top.sv
bench/tb_skew_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the skew front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_skew_top -f build.f -o sim_skew
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_skew > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
